// ==== hdl/wqe_fetch_settings.svh ====
/*
 * WQE fetch unit geometry
 * segment width, cache shape, queue-pair and DMA field sizes
 */
`ifndef WQE_FETCH_SETTINGS_SVH
`define WQE_FETCH_SETTINGS_SVH

// one 16-byte WQE segment
`define WQE_SEG_W       128

// cache geometry as log2 of cells and of slots per cell
`define CELL_NUM_LOG    4
`define SLOT_NUM_LOG    4

`define QPN_W           8
`define DMA_ADDR_W      32
`define SEG_CNT_W       8

// WQE size field inside the first segment
`define SEG_CNT_LSB     70

// derived widths
`define CELL_TAG_W      (`QPN_W - `CELL_NUM_LOG)
`define BUF_ADDR_W      (`CELL_NUM_LOG + `SLOT_NUM_LOG)

`endif

// ==== hdl/wqe_fetch_pkg.sv ====
/*
 * WQE fetch types
 * vector types, stream records and the controller state encoding
 */
`include "wqe_fetch_settings.svh"

package wqe_fetch_pkg;

    typedef logic [`WQE_SEG_W-1:0]  wqe_seg_t;
    typedef logic [`QPN_W-1:0]      qpn_t;
    typedef logic [`CELL_NUM_LOG-1:0] cell_idx_t;
    typedef logic [`CELL_TAG_W-1:0] cell_tag_t;
    typedef logic [`BUF_ADDR_W-1:0] buf_addr_t;
    typedef logic [`SEG_CNT_W-1:0]  seg_cnt_t;
    typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;

    // one host memory region of the send queue
    typedef struct packed {
        logic      valid;
        seg_cnt_t  seg_cnt;
        dma_addr_t addr;
    } region_t;

    typedef struct packed {
        qpn_t    qpn;
        region_t region0;
        region_t region1;
    } sq_meta_t;

    typedef struct packed {
        dma_addr_t addr;
        seg_cnt_t  seg_cnt;
    } dma_req_t;

    typedef struct packed {
        wqe_seg_t seg;
        logic     last;
    } dma_rsp_t;

    typedef struct packed {
        qpn_t     qpn;
        wqe_seg_t seg;
        logic     start;
        logic     last;
    } wqe_out_t;

    typedef enum logic [2:0] {
        st_idle,
        st_judge,
        st_dma_req,
        st_dma_rsp,
        st_fetch
    } fetch_state_t;

endpackage

// ==== hdl/wqe_cache.sv ====
/*
 * WQE cache
 * segment buffer with registered read, and per-cell owner tags
 */
`include "wqe_fetch_settings.svh"

module wqe_cache (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     buf_wen,
    input  wqe_fetch_pkg::buf_addr_t buf_waddr,
    input  wqe_fetch_pkg::wqe_seg_t  buf_wdata,
    input  wqe_fetch_pkg::buf_addr_t buf_raddr,
    output wqe_fetch_pkg::wqe_seg_t  buf_rdata,
    input  wqe_fetch_pkg::cell_idx_t own_idx,
    input  wqe_fetch_pkg::cell_tag_t own_tag,
    input  logic                     own_wen,
    output logic                     hit
);

    localparam int BUF_DEPTH = 1 << `BUF_ADDR_W;
    localparam int CELL_NUM  = 1 << `CELL_NUM_LOG;

    wqe_fetch_pkg::wqe_seg_t  seg_mem [BUF_DEPTH];
    wqe_fetch_pkg::cell_tag_t tag_mem [CELL_NUM];
    logic [CELL_NUM-1:0]      own_vld;
    logic                     tag_match;

    // segment buffer
    always_ff @(posedge clk) begin
        if (buf_wen) begin
            seg_mem[buf_waddr] <= buf_wdata;
        end
    end

    // write-first read so a one-segment refill is seen on the next cycle
    always_ff @(posedge clk) begin
        if (buf_wen && buf_waddr == buf_raddr) begin
            buf_rdata <= buf_wdata;
        end else begin
            buf_rdata <= seg_mem[buf_raddr];
        end
    end

    // owner tags
    always_ff @(posedge clk) begin
        if (own_wen) begin
            tag_mem[own_idx] <= own_tag;
        end
    end

    assign tag_match = (tag_mem[own_idx] == own_tag);

    // valid bits start clear so nothing hits before its first refill
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            own_vld <= '0;
            hit     <= 1'b0;
        end else begin
            if (own_wen) begin
                own_vld[own_idx] <= 1'b1;
            end
            hit <= own_vld[own_idx] && tag_match;
        end
    end

endmodule

// ==== hdl/dma_read_issue.sv ====
/*
 * DMA read issuer
 * sends one read request per valid region, region 0 first
 */
module dma_read_issue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    issue_start,
    input  wqe_fetch_pkg::region_t  region0,
    input  wqe_fetch_pkg::region_t  region1,
    output logic                    issue_done,
    output wqe_fetch_pkg::dma_req_t dma_req,
    output logic                    dma_req_valid,
    input  logic                    dma_req_ready
);

    logic busy;
    logic sel;
    logic req_fire;

    assign req_fire = dma_req_valid && dma_req_ready;

    // selected region drives the request
    assign dma_req_valid   = busy;
    assign dma_req.addr    = sel ? region1.addr : region0.addr;
    assign dma_req.seg_cnt = sel ? region1.seg_cnt : region0.seg_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            sel        <= 1'b0;
            issue_done <= 1'b0;
        end else begin
            issue_done <= 1'b0;
            if (issue_start) begin
                // skip region 0 when it is absent
                busy       <= region0.valid || region1.valid;
                sel        <= !region0.valid;
                issue_done <= !(region0.valid || region1.valid);
            end else if (req_fire) begin
                if (!sel && region1.valid) begin
                    sel <= 1'b1;
                end else begin
                    busy       <= 1'b0;
                    issue_done <= 1'b1;
                end
            end
        end
    end

    // regions come straight from the controller latch, so a stalled request must hold
    assert property (@(posedge clk) disable iff (rst)
        dma_req_valid && !dma_req_ready |=> dma_req_valid && $stable(dma_req));

endmodule

// ==== hdl/fetch_ctrl.sv ====
/*
 * fetch controller
 * judges cache hit or miss, refills the cell from DMA responses
 * and streams the WQE out of the cell with start and last framing
 */
`include "wqe_fetch_settings.svh"

module fetch_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  wqe_fetch_pkg::sq_meta_t  meta,
    input  logic                     meta_valid,
    output logic                     meta_ready,
    input  wqe_fetch_pkg::dma_rsp_t  dma_rsp,
    input  logic                     dma_rsp_valid,
    output logic                     dma_rsp_ready,
    output wqe_fetch_pkg::wqe_out_t  wqe,
    output logic                     wqe_valid,
    input  logic                     wqe_ready,
    output logic                     issue_start,
    output wqe_fetch_pkg::region_t   region0,
    output wqe_fetch_pkg::region_t   region1,
    input  logic                     issue_done,
    output wqe_fetch_pkg::cell_idx_t own_idx,
    output wqe_fetch_pkg::cell_tag_t own_tag,
    output logic                     own_wen,
    input  logic                     hit,
    output logic                     buf_wen,
    output wqe_fetch_pkg::buf_addr_t buf_waddr,
    output wqe_fetch_pkg::wqe_seg_t  buf_wdata,
    output wqe_fetch_pkg::buf_addr_t buf_raddr,
    input  wqe_fetch_pkg::wqe_seg_t  buf_rdata
);

    wqe_fetch_pkg::fetch_state_t state;
    wqe_fetch_pkg::fetch_state_t state_nxt;
    wqe_fetch_pkg::sq_meta_t     meta_q;
    wqe_fetch_pkg::seg_cnt_t     refill_total;
    wqe_fetch_pkg::seg_cnt_t     wr_cnt;
    wqe_fetch_pkg::seg_cnt_t     wqe_total;
    logic [`SLOT_NUM_LOG-1:0]    rd_slot;
    logic [`SLOT_NUM_LOG-1:0]    rd_slot_nxt;
    logic                        judge_ph;
    logic                        judge_done;
    logic                        meta_fire;
    logic                        rsp_fire;
    logic                        wqe_fire;
    logic                        refill_last;
    logic                        beat_last;

    assign meta_ready    = (state == wqe_fetch_pkg::st_idle);
    assign dma_rsp_ready = (state == wqe_fetch_pkg::st_dma_rsp);
    assign wqe_valid     = (state == wqe_fetch_pkg::st_fetch);

    assign meta_fire = meta_valid && meta_ready;
    assign rsp_fire  = dma_rsp_valid && dma_rsp_ready;
    assign wqe_fire  = wqe_valid && wqe_ready;

    // owner lookup and buffer read both need a cycle after the meta latch
    assign judge_done  = (state == wqe_fetch_pkg::st_judge) && judge_ph;
    assign refill_last = (wr_cnt == refill_total - 1'b1);
    assign beat_last   = (wqe_fetch_pkg::seg_cnt_t'(rd_slot) + wqe_fetch_pkg::seg_cnt_t'(1))
                         == wqe_total;

    always_comb begin
        state_nxt = state;
        case (state)
            wqe_fetch_pkg::st_idle:
                if (meta_fire) state_nxt = wqe_fetch_pkg::st_judge;
            wqe_fetch_pkg::st_judge:
                if (judge_done) begin
                    state_nxt = hit ? wqe_fetch_pkg::st_fetch : wqe_fetch_pkg::st_dma_req;
                end
            wqe_fetch_pkg::st_dma_req:
                if (issue_done) state_nxt = wqe_fetch_pkg::st_dma_rsp;
            wqe_fetch_pkg::st_dma_rsp:
                if (rsp_fire && refill_last) state_nxt = wqe_fetch_pkg::st_fetch;
            wqe_fetch_pkg::st_fetch:
                if (wqe_fire && beat_last) state_nxt = wqe_fetch_pkg::st_idle;
            default:
                state_nxt = wqe_fetch_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= wqe_fetch_pkg::st_idle;
            judge_ph <= 1'b0;
            wr_cnt   <= '0;
            rd_slot  <= '0;
        end else begin
            state    <= state_nxt;
            judge_ph <= (state == wqe_fetch_pkg::st_judge) && !judge_ph;
            rd_slot  <= rd_slot_nxt;
            if (state != wqe_fetch_pkg::st_dma_rsp) begin
                wr_cnt <= '0;
            end else if (rsp_fire) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // metadata and refill length held for the whole fetch
    always_ff @(posedge clk) begin
        if (meta_fire) begin
            meta_q       <= meta;
            refill_total <= (meta.region0.valid ? meta.region0.seg_cnt : '0)
                          + (meta.region1.valid ? meta.region1.seg_cnt : '0);
        end
    end

    // size field of slot 0, from the cache on a hit or from the first response beat
    always_ff @(posedge clk) begin
        if (judge_done) begin
            wqe_total <= buf_rdata[`SEG_CNT_LSB +: `SEG_CNT_W];
        end else if (rsp_fire && wr_cnt == '0) begin
            wqe_total <= dma_rsp.seg[`SEG_CNT_LSB +: `SEG_CNT_W];
        end
    end

    assign issue_start = judge_done && !hit;
    assign region0     = meta_q.region0;
    assign region1     = meta_q.region1;

    assign own_idx = meta_q.qpn[`CELL_NUM_LOG-1:0];
    assign own_tag = meta_q.qpn[`QPN_W-1:`CELL_NUM_LOG];
    // cell becomes ours together with its final segment
    assign own_wen = rsp_fire && refill_last;

    assign buf_wen   = rsp_fire;
    assign buf_waddr = {own_idx, wr_cnt[`SLOT_NUM_LOG-1:0]};
    assign buf_wdata = dma_rsp.seg;

    // read pointer sits on slot 0 until the fetch, then moves per accepted beat
    always_comb begin
        if (state != wqe_fetch_pkg::st_fetch) begin
            rd_slot_nxt = '0;
        end else if (wqe_fire) begin
            rd_slot_nxt = beat_last ? '0 : rd_slot + 1'b1;
        end else begin
            rd_slot_nxt = rd_slot;
        end
    end

    assign buf_raddr = {own_idx, rd_slot_nxt};

    assign wqe.qpn   = meta_q.qpn;
    assign wqe.seg   = buf_rdata;
    assign wqe.start = (rd_slot == '0);
    assign wqe.last  = beat_last;

    // beat and framing stay put while the sink stalls
    assert property (@(posedge clk) disable iff (rst)
        wqe_valid && !wqe_ready |=> wqe_valid && $stable(wqe));

    // a refill has to fit in one cell or its slot number wraps onto slot 0
    assert property (@(posedge clk) disable iff (rst)
        buf_wen |-> refill_total != '0 && refill_total <= (1 << `SLOT_NUM_LOG));

endmodule

// ==== hdl/wqe_fetch.sv ====
/*
 * WQE fetch unit
 * serves send-queue WQEs from a small cache, refilling it over DMA on a miss
 */
module wqe_fetch (
    input  logic                     clk,
    input  logic                     rst,
    input  wqe_fetch_pkg::sq_meta_t  meta,
    input  logic                     meta_valid,
    output logic                     meta_ready,
    output wqe_fetch_pkg::dma_req_t  dma_req,
    output logic                     dma_req_valid,
    input  logic                     dma_req_ready,
    input  wqe_fetch_pkg::dma_rsp_t  dma_rsp,
    input  logic                     dma_rsp_valid,
    output logic                     dma_rsp_ready,
    output wqe_fetch_pkg::wqe_out_t  wqe,
    output logic                     wqe_valid,
    input  logic                     wqe_ready
);

    logic                       issue_start;
    logic                       issue_done;
    wqe_fetch_pkg::region_t     region0;
    wqe_fetch_pkg::region_t     region1;
    wqe_fetch_pkg::cell_idx_t   own_idx;
    wqe_fetch_pkg::cell_tag_t   own_tag;
    logic                       own_wen;
    logic                       hit;
    logic                       buf_wen;
    wqe_fetch_pkg::buf_addr_t   buf_waddr;
    wqe_fetch_pkg::wqe_seg_t    buf_wdata;
    wqe_fetch_pkg::buf_addr_t   buf_raddr;
    wqe_fetch_pkg::wqe_seg_t    buf_rdata;

    fetch_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .meta          (meta),
        .meta_valid    (meta_valid),
        .meta_ready    (meta_ready),
        .dma_rsp       (dma_rsp),
        .dma_rsp_valid (dma_rsp_valid),
        .dma_rsp_ready (dma_rsp_ready),
        .wqe           (wqe),
        .wqe_valid     (wqe_valid),
        .wqe_ready     (wqe_ready),
        .issue_start   (issue_start),
        .region0       (region0),
        .region1       (region1),
        .issue_done    (issue_done),
        .own_idx       (own_idx),
        .own_tag       (own_tag),
        .own_wen       (own_wen),
        .hit           (hit),
        .buf_wen       (buf_wen),
        .buf_waddr     (buf_waddr),
        .buf_wdata     (buf_wdata),
        .buf_raddr     (buf_raddr),
        .buf_rdata     (buf_rdata)
    );

    dma_read_issue u_issue (
        .clk           (clk),
        .rst           (rst),
        .issue_start   (issue_start),
        .region0       (region0),
        .region1       (region1),
        .issue_done    (issue_done),
        .dma_req       (dma_req),
        .dma_req_valid (dma_req_valid),
        .dma_req_ready (dma_req_ready)
    );

    wqe_cache u_cache (
        .clk           (clk),
        .rst           (rst),
        .buf_wen       (buf_wen),
        .buf_waddr     (buf_waddr),
        .buf_wdata     (buf_wdata),
        .buf_raddr     (buf_raddr),
        .buf_rdata     (buf_rdata),
        .own_idx       (own_idx),
        .own_tag       (own_tag),
        .own_wen       (own_wen),
        .hit           (hit)
    );

endmodule

// ==== tests/tb_wqe_fetch.sv ====
/*
 * testbench for the WQE fetch unit
 * random metadata, a host memory responder and a mirror of the cache
 */
`include "wqe_fetch_settings.svh"

module tb_wqe_fetch;

    localparam int N_TXN            = 45;
    localparam int CYCLES_PER_FETCH = 200;
    localparam int CYCLE_LIMIT      = N_TXN * CYCLES_PER_FETCH + 20;
    localparam int CELLS            = 1 << `CELL_NUM_LOG;
    localparam int SLOTS            = 1 << `SLOT_NUM_LOG;

    logic                    clk;
    logic                    rst;
    wqe_fetch_pkg::sq_meta_t meta;
    logic                    meta_valid;
    logic                    meta_ready;
    wqe_fetch_pkg::dma_req_t dma_req;
    logic                    dma_req_valid;
    logic                    dma_req_ready;
    wqe_fetch_pkg::dma_rsp_t dma_rsp;
    logic                    dma_rsp_valid;
    logic                    dma_rsp_ready;
    wqe_fetch_pkg::wqe_out_t wqe;
    logic                    wqe_valid;
    logic                    wqe_ready;

    logic [31:0]              lcg_state;
    int                       cycle_cnt = 0;
    int                       err_cnt;
    int                       check_cnt;
    int                       hit_cnt;
    int                       miss_cnt;
    // mirror of the owner table and the segment buffer
    logic                     mirror_valid [CELLS];
    wqe_fetch_pkg::cell_tag_t mirror_tag [CELLS];
    wqe_fetch_pkg::wqe_seg_t  mirror_data [CELLS][SLOTS];
    wqe_fetch_pkg::dma_req_t  exp_reqs [$];
    wqe_fetch_pkg::wqe_seg_t  exp_beats [$];
    wqe_fetch_pkg::dma_rsp_t  rsp_queue [$];
    wqe_fetch_pkg::seg_cnt_t  wqe_size;
    int                       beat_idx;
    logic                     busy;
    logic                     txn_done;
    logic                     expect_idle;
    logic                     meta_fire;
    logic                     rsp_fire;

    wqe_fetch uut (
        .clk           (clk),
        .rst           (rst),
        .meta          (meta),
        .meta_valid    (meta_valid),
        .meta_ready    (meta_ready),
        .dma_req       (dma_req),
        .dma_req_valid (dma_req_valid),
        .dma_req_ready (dma_req_ready),
        .dma_rsp       (dma_rsp),
        .dma_rsp_valid (dma_rsp_valid),
        .dma_rsp_ready (dma_rsp_ready),
        .wqe           (wqe),
        .wqe_valid     (wqe_valid),
        .wqe_ready     (wqe_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // host memory contents, a function of the whole byte address
    function automatic wqe_fetch_pkg::wqe_seg_t host_seg(input logic [31:0] addr);
        return {addr, addr ^ 32'h5a5a_0f0f, ~addr, addr * 32'h9e37_79b9};
    endfunction

    // segment i of a region, first segment carries the WQE size
    function automatic wqe_fetch_pkg::wqe_seg_t region_seg(input logic [31:0] base,
                                                           input int i);
        wqe_fetch_pkg::wqe_seg_t s;
        s = host_seg(base + 32'(i * 16));
        if (i == 0) begin
            s[`SEG_CNT_LSB +: `SEG_CNT_W] = wqe_size;
        end
        return s;
    endfunction

    // directed hit and eviction sequence on cell 3, then random queue pairs
    function automatic wqe_fetch_pkg::qpn_t pick_qpn(input int t);
        logic [31:0] tag;
        logic [31:0] idx;
        tag = next_rand() % 4;
        idx = next_rand() % 6;
        case (t)
            0, 1, 4: return 8'h13;
            2, 3:    return 8'h23;
            default: return wqe_fetch_pkg::qpn_t'((tag << `CELL_NUM_LOG) | idx);
        endcase
    endfunction

    task automatic start_txn(input wqe_fetch_pkg::qpn_t qpn);
        wqe_fetch_pkg::region_t   r [2];
        wqe_fetch_pkg::dma_req_t  req;
        wqe_fetch_pkg::cell_idx_t idx;
        wqe_fetch_pkg::cell_tag_t tag;
        int total;
        int slot;
        int n;
        int k;
        int i;
        idx = qpn[`CELL_NUM_LOG-1:0];
        tag = qpn[`QPN_W-1:`CELL_NUM_LOG];
        for (k = 0; k < 2; k++) begin
            r[k].valid   = (next_rand() % 3) != 0;
            r[k].seg_cnt = wqe_fetch_pkg::seg_cnt_t'(1 + next_rand() % 8);
            r[k].addr    = next_rand() & 32'hffff_fff0;
        end
        if (!r[0].valid && !r[1].valid) begin
            r[0].valid = 1'b1;
        end
        exp_reqs.delete();
        exp_beats.delete();
        if (mirror_valid[idx] && mirror_tag[idx] == tag) begin
            hit_cnt++;
        end else begin
            miss_cnt++;
            total = (r[0].valid ? int'(r[0].seg_cnt) : 0) + (r[1].valid ? int'(r[1].seg_cnt) : 0);
            wqe_size = wqe_fetch_pkg::seg_cnt_t'(1 + next_rand() % total);
            slot = 0;
            for (k = 0; k < 2; k++) begin
                if (r[k].valid) begin
                    req.addr    = r[k].addr;
                    req.seg_cnt = r[k].seg_cnt;
                    exp_reqs.push_back(req);
                    for (i = 0; i < int'(r[k].seg_cnt); i++) begin
                        mirror_data[idx][slot] = region_seg(r[k].addr, i);
                        slot++;
                    end
                end
            end
            mirror_valid[idx] = 1'b1;
            mirror_tag[idx]   = tag;
        end
        n = int'(mirror_data[idx][0][`SEG_CNT_LSB +: `SEG_CNT_W]);
        for (i = 0; i < n; i++) begin
            exp_beats.push_back(mirror_data[idx][i]);
        end
        meta.qpn     = qpn;
        meta.region0 = r[0];
        meta.region1 = r[1];
        meta_valid   = 1'b1;
        beat_idx     = 0;
        txn_done     = 1'b0;
    endtask

    task automatic check_meta();
        if (expect_idle) begin
            check_cnt++;
            if (!meta_ready) begin
                err_cnt++;
                $display("meta_ready did not rise after the last beat at %0t", $time);
            end
            expect_idle = 1'b0;
        end else if (busy && meta_ready) begin
            err_cnt++;
            $display("meta_ready went high in the middle of a fetch at %0t", $time);
        end
        meta_fire = meta_valid && meta_ready;
        if (meta_fire) begin
            busy = 1'b1;
        end
    endtask

    // compare the request, then queue the host memory answer
    task automatic take_request();
        wqe_fetch_pkg::dma_rsp_t rsp;
        int i;
        check_cnt++;
        if (exp_reqs.size() == 0) begin
            err_cnt++;
            $display("unexpected DMA request at %0t, addr %h", $time, dma_req.addr);
        end else begin
            if (dma_req != exp_reqs[0]) begin
                err_cnt++;
                $display("Error at %0t: DMA request %h/%0d, expected %h/%0d", $time,
                         dma_req.addr, dma_req.seg_cnt, exp_reqs[0].addr, exp_reqs[0].seg_cnt);
            end
            void'(exp_reqs.pop_front());
        end
        for (i = 0; i < int'(dma_req.seg_cnt); i++) begin
            rsp.seg  = region_seg(dma_req.addr, i);
            rsp.last = (i == int'(dma_req.seg_cnt) - 1);
            rsp_queue.push_back(rsp);
        end
    endtask

    task automatic check_beat();
        check_cnt++;
        if (beat_idx >= exp_beats.size()) begin
            err_cnt++;
            $display("extra output beat %0d at %0t", beat_idx, $time);
        end else if (wqe.seg != exp_beats[beat_idx]) begin
            err_cnt++;
            $display("Error at %0t: beat %0d seg %h, expected %h", $time, beat_idx,
                     wqe.seg, exp_beats[beat_idx]);
        end
        if (wqe.qpn != meta.qpn) begin
            err_cnt++;
            $display("Error at %0t: beat qpn %h, expected %h", $time, wqe.qpn, meta.qpn);
        end
        if (wqe.start != (beat_idx == 0) || wqe.last != (beat_idx == exp_beats.size() - 1)) begin
            err_cnt++;
            $display("Error at %0t: beat %0d of %0d has start %b last %b", $time, beat_idx,
                     exp_beats.size(), wqe.start, wqe.last);
        end
        beat_idx++;
        if (wqe.last) begin
            busy        = 1'b0;
            txn_done    = 1'b1;
            expect_idle = 1'b1;
        end
    endtask

    task automatic drive_inputs();
        if (meta_fire) begin
            meta_valid = 1'b0;
        end
        dma_req_ready = (next_rand() % 3) != 0;
        wqe_ready     = (next_rand() % 4) != 0;
        if (rsp_fire) begin
            void'(rsp_queue.pop_front());
        end
        // a response beat holds until it is taken
        if (!dma_rsp_valid || rsp_fire) begin
            dma_rsp_valid = rsp_queue.size() != 0 && (next_rand() % 4) != 0;
        end
        if (dma_rsp_valid) begin
            dma_rsp = rsp_queue[0];
        end
    endtask

    // sample at the falling edge, drive just after the rising edge
    task automatic run_cycle();
        logic req_fire;
        logic wqe_fire;
        @(negedge clk);
        req_fire = dma_req_valid && dma_req_ready;
        wqe_fire = wqe_valid && wqe_ready;
        rsp_fire = dma_rsp_valid && dma_rsp_ready;
        check_meta();
        if (req_fire) begin
            take_request();
        end
        if (wqe_fire) begin
            check_beat();
        end
        @(posedge clk);
        #2;
        drive_inputs();
    endtask

    initial begin
        int t;
        int gap;
        lcg_state     = 32'd97;
        rst           = 1'b1;
        meta          = '0;
        meta_valid    = 1'b0;
        dma_req_ready = 1'b0;
        dma_rsp       = '0;
        dma_rsp_valid = 1'b0;
        wqe_ready     = 1'b0;
        err_cnt       = 0;
        check_cnt     = 0;
        hit_cnt       = 0;
        miss_cnt      = 0;
        busy          = 1'b0;
        txn_done      = 1'b0;
        expect_idle   = 1'b0;
        meta_fire     = 1'b0;
        rsp_fire      = 1'b0;
        wqe_size      = '0;
        for (t = 0; t < CELLS; t++) begin
            mirror_valid[t] = 1'b0;
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // idle outputs right after reset
        @(negedge clk);
        check_cnt++;
        if (!meta_ready || dma_req_valid || dma_rsp_ready || wqe_valid) begin
            err_cnt++;
            $display("outputs are not idle after reset at %0t", $time);
        end
        @(posedge clk);
        #2;

        for (t = 0; t < N_TXN; t++) begin
            gap = int'(next_rand() % 3);
            repeat (gap) run_cycle();
            start_txn(pick_qpn(t));
            while (!txn_done) begin
                run_cycle();
            end
            if (exp_reqs.size() != 0 || rsp_queue.size() != 0) begin
                err_cnt++;
                $display("fetch %0d ended with DMA requests or responses left over", t);
            end
        end
        run_cycle();

        $display("%0d fetches, %0d hits, %0d misses, %0d checks, %0d errors",
                 N_TXN, hit_cnt, miss_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/wqe_fetch_pkg.sv
hdl/wqe_cache.sv
hdl/dma_read_issue.sv
hdl/fetch_ctrl.sv
hdl/wqe_fetch.sv
tests/tb_wqe_fetch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the WQE fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_wqe_fetch \
    -f flist.f \
    --Mdir obj_dir -o sim_wqe_fetch

./obj_dir/sim_wqe_fetch | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation finished without failures"
